// File: mdp_predictor_testdata.txt
# W/B: pc38 asid mdp, S: wait for idle, R: fetch_idx asid lane0 lane1 lane2 lane3, X: random
# all values hex; W waits for the buffer to drain, B does not
W 040 000 11
W 041 000 22
W 042 000 33
W 043 000 44
R 010 000 11 22 33 44
# single lane update leaves the other lanes alone
W 041 000 a5
R 010 000 11 a5 33 44
W 48c 045 01
W 48d 045 02
W 48e 045 03
W 48f 045 04
W 488 045 f0
W 489 045 f1
W 48a 045 f2
W 48b 045 f3
R 123 045 01 02 03 04
R 122 045 f0 f1 f2 f3
# other index and asid with the same xor, set 166
W 1c00000402 066 77
R 700000100 066 01 02 77 04
R 123 045 01 02 77 04
R 122 045 f0 f1 f2 f3
# five back to back updates, lane 1 written twice
B 3fc 1ff 10
B 3fd 1ff 20
B 3fe 1ff 30
B 3ff 1ff 40
B 3fd 1ff 2b
S
R 0ff 1ff 10 2b 30 40
B 040 000 5a
B 48f 045 9c
B 042 000 c3
B 040 000 5b
B 48f 045 9d
B 043 000 e1
S
R 010 000 5b a5 c3 e1
R 123 045 01 02 77 9d
R 0ff 1ff 10 2b 30 40
X

// File: build.f
+incdir+.
corep.sv
bram_1rport_1wport.sv
mdpt.sv
mdp_update_buffer.sv
mdp_predictor.sv
tb_mdp_predictor.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/10ps -f build.f \
        --top-module tb_mdp_predictor -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Testbench passed$"; then
    exit 0
fi
exit 1

// File: tb_mdp_predictor.sv
/*
    tb_mdp_predictor
    self-checking testbench for the memory dependence predictor,
    commands and expected lanes come from the testdata file,
    a reference model of the table cross-checks them
*/

`timescale 1ns/10ps
`default_nettype none

`include "corep_params.svh"

module tb_mdp_predictor;

    import corep::*;

    logic        CLK;
    logic        rst_n;
    logic        read_req_valid;
    fetch_idx_t  read_req_fetch_idx;
    asid_t       read_req_asid;
    mdpt_set_t   read_resp_mdp_by_lane;
    logic        update_valid;
    pc38_t       update_pc38;
    asid_t       update_asid;
    mdp_t        update_mdp;
    logic        update_full;
    logic        update_idle;

    // reference model, one byte per set and lane
    mdp_t model_mdp     [`COREP_MDPT_SETS][`COREP_FETCH_LANES];
    logic model_written [`COREP_MDPT_SETS][`COREP_FETCH_LANES];

    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_count  = 0;
    int          cycle_limit  = 2000;
    logic [63:0] rng_state    = 64'd39;

    mdp_predictor u_dut (
        .CLK                   (CLK),
        .rst_n                 (rst_n),
        .read_req_valid        (read_req_valid),
        .read_req_fetch_idx    (read_req_fetch_idx),
        .read_req_asid         (read_req_asid),
        .read_resp_mdp_by_lane (read_resp_mdp_by_lane),
        .update_valid          (update_valid),
        .update_pc38           (update_pc38),
        .update_asid           (update_asid),
        .update_mdp            (update_mdp),
        .update_full           (update_full),
        .update_idle           (update_idle)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    // set index: low fetch index bits xor asid
    function automatic mdpt_idx_t set_of(input fetch_idx_t idx, input asid_t asid);
        return idx[`COREP_MDPT_IDX_WIDTH-1:0] ^ asid;
    endfunction

    function automatic logic [63:0] xorshift(input logic [63:0] x);
        logic [63:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 7);
        s = s ^ (s << 17);
        return s;
    endfunction

    function automatic void check_value(input string name, input logic [31:0] exp,
                                        input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s expected %0h actual %0h", name, exp, act);
        end
    endfunction

    // one push on the next edge, model follows
    task automatic push_update(input pc38_t pc, input asid_t asid, input mdp_t mdp);
        mdpt_idx_t h;
        if (update_full) begin
            other_errors++;
            $display("update buffer was full when a push was due");
        end
        update_valid = 1'b1;
        update_pc38  = pc;
        update_asid  = asid;
        update_mdp   = mdp;
        h = set_of(pc.idx, asid);
        model_mdp[h][pc.lane]     = mdp;
        model_written[h][pc.lane] = 1'b1;
        @(negedge CLK);
        update_valid = 1'b0;
    endtask

    task automatic wait_idle;
        while (!update_idle) begin
            if (update_full) begin
                other_errors++;
                $display("update buffer reported full while draining");
            end
            @(negedge CLK);
        end
    endtask

    // read, then one idle cycle pointing at another set to see the response hold
    task automatic do_read(input string name, input fetch_idx_t idx, input asid_t asid,
                           input mdpt_set_t exp_set);
        read_req_valid     = 1'b1;
        read_req_fetch_idx = idx;
        read_req_asid      = asid;
        @(negedge CLK);
        for (int l = 0; l < `COREP_FETCH_LANES; l++) begin
            check_value($sformatf("%s lane %0d", name, l),
                        32'(exp_set[l]), 32'(read_resp_mdp_by_lane[l]));
        end
        read_req_valid     = 1'b0;
        read_req_fetch_idx = ~idx;
        read_req_asid      = asid;
        @(negedge CLK);
        for (int l = 0; l < `COREP_FETCH_LANES; l++) begin
            check_value($sformatf("%s hold lane %0d", name, l),
                        32'(exp_set[l]), 32'(read_resp_mdp_by_lane[l]));
        end
    endtask

    // --------------------------------------------------
    // random block over fully written sets
    // --------------------------------------------------
    task automatic run_random_block;
        mdpt_idx_t   full_sets[$];
        logic        all_lanes;
        logic [63:0] r;
        int          pick;
        mdpt_idx_t   h;
        asid_t       a;
        mdpt_set_t   exp_set;
        for (int s = 0; s < `COREP_MDPT_SETS; s++) begin
            all_lanes = 1'b1;
            for (int l = 0; l < `COREP_FETCH_LANES; l++) begin
                all_lanes = all_lanes & model_written[s][l];
            end
            if (all_lanes) begin
                full_sets.push_back(mdpt_idx_t'(s));
            end
        end
        if (full_sets.size() == 0) begin
            other_errors++;
            $display("random block found no fully written set");
            return;
        end
        for (int i = 0; i < 64; i++) begin
            rng_state = xorshift(rng_state);
            r = rng_state;
            pick = {16'd0, r[15:0]} % full_sets.size();
            h = full_sets[pick];
            a = r[24:16];
            // random upper index bits, low bits chosen to land on set h
            push_update(pc38_t'({r[61:35], h ^ a, r[26:25]}), a, r[34:27]);
            wait_idle();
            rng_state = xorshift(rng_state);
            r = rng_state;
            pick = {16'd0, r[15:0]} % full_sets.size();
            h = full_sets[pick];
            a = r[24:16];
            for (int l = 0; l < `COREP_FETCH_LANES; l++) begin
                exp_set[l] = model_mdp[h][l];
            end
            do_read($sformatf("random %0d", i), {r[61:35], h ^ a}, a, exp_set);
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int               fd;
        int               rc;
        int               n_cmds;
        int               n_reads;
        logic [7:0]       cmd;
        logic [8*128-1:0] linebuf;
        logic [37:0]      pc_raw;
        logic [35:0]      idx_raw;
        logic [8:0]       asid_raw;
        logic [7:0]       mdp_raw;
        logic [7:0]       e0;
        logic [7:0]       e1;
        logic [7:0]       e2;
        logic [7:0]       e3;
        mdpt_set_t        exp_set;
        mdpt_idx_t        h;
        n_cmds             = 0;
        n_reads            = 0;
        rst_n              = 1'b0;
        read_req_valid     = 1'b0;
        read_req_fetch_idx = '0;
        read_req_asid      = '0;
        update_valid       = 1'b0;
        update_pc38        = '0;
        update_asid        = '0;
        update_mdp         = '0;
        for (int s = 0; s < `COREP_MDPT_SETS; s++) begin
            for (int l = 0; l < `COREP_FETCH_LANES; l++) begin
                model_written[s][l] = 1'b0;
            end
        end

        // first pass only counts commands for the cycle limit
        fd = $fopen("mdp_predictor_testdata.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open mdp_predictor_testdata.txt");
        end else begin
            while ($fscanf(fd, " %c", cmd) == 1) begin
                rc = $fgets(linebuf, fd);
                if (cmd != "#") begin
                    n_cmds++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = 4 * n_cmds + 2000;

        repeat (16) @(negedge CLK);
        rst_n = 1'b1;
        @(negedge CLK);
        check_value("reset idle", 32'd1, 32'(update_idle));
        check_value("reset full", 32'd0, 32'(update_full));

        fd = $fopen("mdp_predictor_testdata.txt", "r");
        if (fd != 0) begin
            while ($fscanf(fd, " %c", cmd) == 1) begin
                case (cmd)
                    "#": rc = $fgets(linebuf, fd);
                    "W", "B": begin
                        rc = $fscanf(fd, "%h %h %h", pc_raw, asid_raw, mdp_raw);
                        if (rc != 3) begin
                            other_errors++;
                            $display("malformed update line in testdata");
                        end
                        push_update(pc38_t'(pc_raw), asid_raw, mdp_raw);
                        if (cmd == "W") begin
                            wait_idle();
                        end
                    end
                    "S": wait_idle();
                    "R": begin
                        rc = $fscanf(fd, "%h %h %h %h %h %h",
                                     idx_raw, asid_raw, e0, e1, e2, e3);
                        if (rc != 6) begin
                            other_errors++;
                            $display("malformed read line in testdata");
                        end
                        n_reads++;
                        exp_set = {e3, e2, e1, e0};
                        h = set_of(idx_raw, asid_raw);
                        for (int l = 0; l < `COREP_FETCH_LANES; l++) begin
                            if (!model_written[h][l] || model_mdp[h][l] !== exp_set[l]) begin
                                other_errors++;
                                $display("testdata read %0d lane %0d disagrees with the model",
                                         n_reads, l);
                            end
                        end
                        do_read($sformatf("read %0d", n_reads), idx_raw, asid_raw, exp_set);
                    end
                    "X": run_random_block();
                    default: begin
                        other_errors++;
                        $display("unknown command %c in testdata", cmd);
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mdp_predictor.sv
/*
    mdp_predictor
    memory dependence predictor top level
    training updates queue in the update buffer, which
    drains one per cycle into the prediction table
*/

`timescale 1ns/10ps
`default_nettype none

module mdp_predictor (
    input  logic               CLK,
    input  logic               rst_n,

    // read request and response
    input  logic               read_req_valid,
    input  corep::fetch_idx_t  read_req_fetch_idx,
    input  corep::asid_t       read_req_asid,
    output corep::mdpt_set_t   read_resp_mdp_by_lane,

    // training updates
    input  logic               update_valid,
    input  corep::pc38_t       update_pc38,
    input  corep::asid_t       update_asid,
    input  corep::mdp_t        update_mdp,

    // buffer status
    output logic               update_full,
    output logic               update_idle
);

    import corep::*;

    // --------------------------------------------------
    // buffer to table
    // --------------------------------------------------
    logic   drain_valid;
    pc38_t  drain_pc38;
    asid_t  drain_asid;
    mdp_t   drain_mdp;

    mdp_update_buffer u_update_buffer (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .push        (update_valid),
        .push_pc38   (update_pc38),
        .push_asid   (update_asid),
        .push_mdp    (update_mdp),
        .full        (update_full),
        .idle        (update_idle),
        .drain_valid (drain_valid),
        .drain_pc38  (drain_pc38),
        .drain_asid  (drain_asid),
        .drain_mdp   (drain_mdp)
    );

    // table takes every drained update
    mdpt u_mdpt (
        .CLK                   (CLK),
        .rst_n                 (rst_n),
        .read_req_valid        (read_req_valid),
        .read_req_fetch_idx    (read_req_fetch_idx),
        .read_req_asid         (read_req_asid),
        .read_resp_mdp_by_lane (read_resp_mdp_by_lane),
        .update_valid          (drain_valid),
        .update_pc38           (drain_pc38),
        .update_asid           (drain_asid),
        .update_mdp            (drain_mdp)
    );

endmodule

`default_nettype wire

// File: mdp_update_buffer.sv
/*
    mdp_update_buffer
    small circular FIFO in front of the prediction table
    absorbs training update bursts, presents the head as a
    drain strobe and pops it in the same cycle
*/

`timescale 1ns/10ps
`default_nettype none

`include "corep_params.svh"

module mdp_update_buffer (
    input  logic          CLK,
    input  logic          rst_n,

    // push side
    input  logic          push,
    input  corep::pc38_t  push_pc38,
    input  corep::asid_t  push_asid,
    input  corep::mdp_t   push_mdp,

    // status levels
    output logic          full,
    output logic          idle,

    // drain side, table write strobe
    output logic          drain_valid,
    output corep::pc38_t  drain_pc38,
    output corep::asid_t  drain_asid,
    output corep::mdp_t   drain_mdp
);

    import corep::*;

    localparam int DEPTH = `COREP_UPDATE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    pc38_t  buf_pc38 [DEPTH];
    asid_t  buf_asid [DEPTH];
    mdp_t   buf_mdp  [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic pop;
    logic push_accept;

    // --------------------------------------------------
    // status and handshake-free strobes
    // --------------------------------------------------
    assign idle        = (count == '0);
    assign full        = (count == CNT_W'(DEPTH));
    assign drain_valid = !idle;

    // head leaves every cycle the FIFO holds something
    assign pop = drain_valid;

    // a full buffer still takes a push when the head pops
    assign push_accept = push && (!full || pop);

    assign drain_pc38 = buf_pc38[rd_ptr];
    assign drain_asid = buf_asid[rd_ptr];
    assign drain_mdp  = buf_mdp[rd_ptr];

    // payload, no reset
    always_ff @(posedge CLK) begin
        if (push_accept) begin
            buf_pc38[wr_ptr] <= push_pc38;
            buf_asid[wr_ptr] <= push_asid;
            buf_mdp[wr_ptr]  <= push_mdp;
        end
    end

    // --------------------------------------------------
    // pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_accept) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_accept, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: mdpt.sv
/*
    mdpt
    memory dependence prediction table
    one byte prediction per fetch lane, sets picked by
    a fetch index / asid hash, one-cycle read of a whole set
    and a single-lane byte-masked update
*/

`timescale 1ns/10ps
`default_nettype none

`include "corep_params.svh"

module mdpt (
    input  logic               CLK,
    input  logic               rst_n,

    // read request
    input  logic               read_req_valid,
    input  corep::fetch_idx_t  read_req_fetch_idx,
    input  corep::asid_t       read_req_asid,

    // read response, one cycle later
    output corep::mdpt_set_t   read_resp_mdp_by_lane,

    // update
    input  logic               update_valid,
    input  corep::pc38_t       update_pc38,
    input  corep::asid_t       update_asid,
    input  corep::mdp_t        update_mdp
);

    import corep::*;

    localparam int BYTES_PER_MDP = `COREP_MDP_WIDTH / 8;

    // --------------------------------------------------
    // index hash
    // --------------------------------------------------
    // low fetch index bits xor asid
    function automatic mdpt_idx_t index_hash(input fetch_idx_t fetch_idx, input asid_t asid);
        index_hash = fetch_idx[`COREP_MDPT_IDX_WIDTH-1:0] ^ asid;
    endfunction

    // ram read side
    mdpt_idx_t   bram_read_index;
    mdpt_set_t   bram_read_set;

    // ram write side
    logic [`COREP_FETCH_LANES-1:0][BYTES_PER_MDP-1:0] bram_write_byten;
    mdpt_idx_t   bram_write_index;
    mdpt_set_t   bram_write_set;

    fetch_lane_t update_lane;

    // --------------------------------------------------
    // read
    // --------------------------------------------------
    assign bram_read_index       = index_hash(read_req_fetch_idx, read_req_asid);
    assign read_resp_mdp_by_lane = bram_read_set;

    // --------------------------------------------------
    // write
    // --------------------------------------------------
    assign update_lane      = update_pc38.lane;
    assign bram_write_index = index_hash(update_pc38.idx, update_asid);

    // same byte in every lane, only the target lane enabled
    always_comb begin
        bram_write_byten = '0;
        if (update_valid) begin
            bram_write_byten[update_lane] = '1;
        end
        for (int lane = 0; lane < `COREP_FETCH_LANES; lane++) begin
            bram_write_set[lane] = update_mdp;
        end
    end

    bram_1rport_1wport #(
        .INNER_WIDTH ($bits(mdpt_set_t)),
        .OUTER_WIDTH (`COREP_MDPT_SETS)
    ) u_mdpt_array_bram (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .ren      (read_req_valid),
        .rindex   (bram_read_index),
        .rdata    (bram_read_set),
        .wen_byte (bram_write_byten),
        .windex   (bram_write_index),
        .wdata    (bram_write_set)
    );

endmodule

`default_nettype wire

// File: bram_1rport_1wport.sv
/*
    bram_1rport_1wport
    one read port, one write port block RAM
    registered read with enable, read-first on collision,
    per-byte write enables on the write port
*/

`timescale 1ns/10ps
`default_nettype none

module bram_1rport_1wport #(
    parameter int INNER_WIDTH = 32,
    parameter int OUTER_WIDTH = 512
) (
    input  logic                           CLK,
    input  logic                           rst_n,

    // read port
    input  logic                           ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] rindex,
    output logic [INNER_WIDTH-1:0]         rdata,

    // write port
    input  logic [INNER_WIDTH/8-1:0]       wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    localparam int NUM_BYTES = INNER_WIDTH / 8;

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // byte lanes written independently
    always_ff @(posedge CLK) begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            if (wen_byte[b]) begin
                mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // --------------------------------------------------
    // read register
    // --------------------------------------------------
    // samples the array before this edge's write lands,
    // so a same-row collision returns the old row
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[rindex];
        end
    end

endmodule

`default_nettype wire

// File: corep.sv
/*
    corep package
    shared types of the memory dependence predictor,
    sized from the parameter header
*/

`default_nettype none

`include "corep_params.svh"

package corep;

    // --------------------------------------------------
    // fetch addressing
    // --------------------------------------------------
    // pc without its lane and byte bits
    typedef logic [`COREP_FETCH_IDX_WIDTH-1:0]  fetch_idx_t;
    typedef logic [`COREP_FETCH_LANE_WIDTH-1:0] fetch_lane_t;

    // idx in the high bits, lane below it
    typedef struct packed {
        fetch_idx_t  idx;
        fetch_lane_t lane;
    } pc38_t;

    typedef logic [`COREP_ASID_WIDTH-1:0] asid_t;

    // --------------------------------------------------
    // table entries
    // --------------------------------------------------
    typedef logic [`COREP_MDPT_IDX_WIDTH-1:0] mdpt_idx_t;
    typedef logic [`COREP_MDP_WIDTH-1:0]      mdp_t;

    // lane 0 sits in the low byte
    typedef mdp_t [`COREP_FETCH_LANES-1:0] mdpt_set_t;

endpackage

`default_nettype wire

// File: corep_params.svh
/*
    core prediction parameters
    sizes shared by the memory dependence predictor
    and its package types
*/

`ifndef COREP_PARAMS_SVH
`define COREP_PARAMS_SVH

// --------------------------------------------------
// fetch geometry
// --------------------------------------------------
// lanes per fetch block, one prediction each
`define COREP_FETCH_LANES       4
`define COREP_FETCH_LANE_WIDTH  2
// pc bits above the lane and byte offset
`define COREP_FETCH_IDX_WIDTH   36

// --------------------------------------------------
// table geometry
// --------------------------------------------------
`define COREP_MDPT_SETS         512
`define COREP_MDPT_IDX_WIDTH    9
`define COREP_ASID_WIDTH        9
// one byte per prediction
`define COREP_MDP_WIDTH         8

// training update buffer entries
`define COREP_UPDATE_DEPTH      4

`endif
